/* verilog/fe_pkg.sv */
// shared widths and types for the fetch front end
// fetch addresses are 32-byte aligned, low OFF_W bits always zero
package fe_pkg;

  localparam int IP_W        = 43;
  localparam int OFF_W       = 5;   // block offset bits
  localparam int FETCH_BYTES = 32;
  localparam logic [IP_W-1:0] RESET_IP = '0;

  localparam int GHT_W      = 8;
  localparam int PRED_IDX_W = 8;    // 256 votes per table
  localparam int TB_IDX_W   = 6;    // 64 target buffer entries
  localparam int RAS_DEPTH  = 8;
  localparam int RAS_PTR_W  = 3;

  // tag is everything above index and offset
  localparam int TAG_W = IP_W - TB_IDX_W - OFF_W;
  localparam int TGT_W = IP_W - OFF_W;

  typedef logic [IP_W-1:0]  ip_t;
  typedef logic [GHT_W-1:0] hist_t;   // newest outcome in bit 0

  typedef enum logic [1:0] {
    BR_COND   = 2'd0,
    BR_UNCOND = 2'd1,
    BR_CALL   = 2'd2,
    BR_RET    = 2'd3
  } br_kind_t;

  // 73 bits, target kept without offset bits
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic [TGT_W-1:0] target;
    br_kind_t         kind;
  } tb_entry_t;

endpackage

/* verilog/table_ram.sv */
// register array, combinational read, write lands at next edge
// whole array cleared by reset, so keep DEPTH_W small
`timescale 1ns/1ns

module table_ram #(
  parameter type entry_t = logic,
  parameter int  DEPTH_W = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [DEPTH_W-1:0] rd_addr,
  output entry_t             rd_data,
  input  logic               wr_en,
  input  logic [DEPTH_W-1:0] wr_addr,
  input  entry_t             wr_data
);

  entry_t mem [1 << DEPTH_W];

  assign rd_data = mem[rd_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < (1 << DEPTH_W); i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

/* verilog/dir_predictor.sv */
// three one-bit vote tables, prediction is their xor
// flip_en steals the read port, so vote is only valid with flip_en low
`timescale 1ns/1ns

module dir_predictor import fe_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  ip_t   lookup_ip,
  input  hist_t lookup_hist,
  output logic  vote,
  input  logic  flip_en,
  input  ip_t   flip_ip,
  input  hist_t flip_hist
);

  logic [2:0] ent;     // one vote per table
  logic [1:0] sel_q;   // table to flip next, 0=A 1=B 2=C

  // A mixes more address, C is pure history
  function automatic logic [PRED_IDX_W-1:0] vote_index(
    input int    tbl,
    input ip_t   ip,
    input hist_t h
  );
    case (tbl)
      0:       vote_index = {ip[10:5], h[1:0]};
      1:       vote_index = {ip[8:5], h[3:0]};
      default: vote_index = h[7:0];
    endcase
  endfunction

  for (genvar t = 0; t < 3; t++) begin : g_tbl
    logic [PRED_IDX_W-1:0] rd_idx;
    logic                  wr_sel;

    // during a flip the read returns the entry about to be inverted
    assign rd_idx = flip_en ? vote_index(t, flip_ip, flip_hist)
                            : vote_index(t, lookup_ip, lookup_hist);
    assign wr_sel = flip_en && (sel_q == 2'(t));

    table_ram #(
      .entry_t (logic),
      .DEPTH_W (PRED_IDX_W)
    ) u_votes (
      .clk     (clk),
      .rst     (rst),
      .rd_addr (rd_idx),
      .rd_data (ent[t]),
      .wr_en   (wr_sel),
      .wr_addr (rd_idx),
      .wr_data (~ent[t])
    );
  end

  assign vote = ^ent;

  always_ff @(posedge clk) begin
    if (rst) begin
      sel_q <= 2'd0;
    end else if (flip_en) begin
      sel_q <= (sel_q == 2'd2) ? 2'd0 : sel_q + 2'd1;   // A, B, C, A ...
    end
  end

endmodule

/* verilog/target_buffer.sv */
// direct mapped, indexed by address bits 10:5, tag is bits 42:11
// an install always overwrites, no replacement choice
`timescale 1ns/1ns

module target_buffer import fe_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  ip_t      lookup_ip,
  output logic     hit,
  output br_kind_t hit_kind,
  output ip_t      hit_target,
  input  logic     install_en,
  input  ip_t      install_ip,
  input  ip_t      install_target,
  input  br_kind_t install_kind
);

  logic [TB_IDX_W-1:0] lookup_idx;
  logic [TB_IDX_W-1:0] install_idx;
  logic [TAG_W-1:0]    lookup_tag;
  tb_entry_t           rd_entry;
  tb_entry_t           wr_entry;

  assign lookup_idx  = lookup_ip[OFF_W +: TB_IDX_W];
  assign lookup_tag  = lookup_ip[IP_W-1 -: TAG_W];
  assign install_idx = install_ip[OFF_W +: TB_IDX_W];

  always_comb begin
    wr_entry.valid  = 1'b1;
    wr_entry.tag    = install_ip[IP_W-1 -: TAG_W];
    wr_entry.target = install_target[IP_W-1:OFF_W];   // offset dropped
    wr_entry.kind   = install_kind;
  end

  table_ram #(
    .entry_t (tb_entry_t),
    .DEPTH_W (TB_IDX_W)
  ) u_entries (
    .clk     (clk),
    .rst     (rst),
    .rd_addr (lookup_idx),
    .rd_data (rd_entry),
    .wr_en   (install_en),
    .wr_addr (install_idx),
    .wr_data (wr_entry)
  );

  assign hit        = rd_entry.valid && (rd_entry.tag == lookup_tag);
  assign hit_kind   = rd_entry.kind;
  assign hit_target = {rd_entry.target, {OFF_W{1'b0}}};

endmodule

/* verilog/return_stack.sv */
// circular return stack, overflow silently wraps over oldest entries
// push_ip is the calling block, the stored return point is the block after it
`timescale 1ns/1ns

module return_stack import fe_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  ip_t  push_ip,
  input  logic pop,
  output ip_t  top_ip
);

  logic [RAS_PTR_W-1:0] ptr_q;
  logic [RAS_PTR_W-1:0] ptr_inc;
  logic [RAS_PTR_W-1:0] ptr_dec;
  ip_t                  ret_ip;

  assign ptr_inc = (ptr_q == RAS_PTR_W'(RAS_DEPTH - 1)) ? '0 : ptr_q + 1'b1;
  assign ptr_dec = (ptr_q == '0) ? RAS_PTR_W'(RAS_DEPTH - 1) : ptr_q - 1'b1;
  assign ret_ip  = push_ip + IP_W'(FETCH_BYTES);

  table_ram #(
    .entry_t (ip_t),
    .DEPTH_W (RAS_PTR_W)
  ) u_stack (
    .clk     (clk),
    .rst     (rst),
    .rd_addr (ptr_q),       // top lives at the pointer
    .rd_data (top_ip),
    .wr_en   (push),
    .wr_addr (ptr_inc),
    .wr_data (ret_ip)
  );

  // a block is never both call and return
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q <= '0;
    end else if (push) begin
      ptr_q <= ptr_inc;
    end else if (pop) begin
      ptr_q <= ptr_dec;
    end
  end

endmodule

/* verilog/fetch_ctrl.sv */
// four-phase req/ack fetch sequencer, one fetch in flight
// resolve must arrive with fetch_req low, it delays the next request by one cycle
`timescale 1ns/1ns

module fetch_ctrl import fe_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  output logic     fetch_req,
  input  logic     fetch_ack,
  output ip_t      fetch_ip,
  output hist_t    fetch_hist,
  input  logic     resolve_valid,
  input  ip_t      resolve_ip,
  input  ip_t      resolve_target,
  input  br_kind_t resolve_kind,
  input  logic     resolve_taken,
  input  hist_t    resolve_hist,
  input  logic     resolve_mispredict,
  input  logic     tb_hit,
  input  br_kind_t tb_kind,
  input  ip_t      tb_target,
  input  logic     vote,
  input  ip_t      ras_top,
  output logic     ras_push,
  output logic     ras_pop,
  output logic     tb_install_en,
  output logic     flip_en
);

  logic  req_q;
  ip_t   ip_q;
  hist_t hist_q;
  logic  done;        // handshake completes at this edge
  ip_t   seq_ip;
  ip_t   next_ip;
  hist_t next_hist;
  ip_t   redir_ip;
  hist_t redir_hist;

  assign fetch_req  = req_q;
  assign fetch_ip   = ip_q;
  assign fetch_hist = hist_q;

  assign done   = req_q && fetch_ack;
  assign seq_ip = ip_q + IP_W'(FETCH_BYTES);

  always_comb begin
    next_ip   = seq_ip;
    next_hist = hist_q;   // miss leaves history alone
    if (tb_hit) begin
      case (tb_kind)
        BR_RET:            next_ip = ras_top;
        BR_CALL, BR_UNCOND: next_ip = tb_target;
        default: begin
          next_ip   = vote ? tb_target : seq_ip;
          next_hist = {hist_q[GHT_W-2:0], vote};
        end
      endcase
    end
  end

  // back end knows the real outcome, history rebuilt from its snapshot
  assign redir_ip   = resolve_taken ? resolve_target : resolve_ip + IP_W'(FETCH_BYTES);
  assign redir_hist = (resolve_kind == BR_COND) ? {resolve_hist[GHT_W-2:0], resolve_taken}
                                                : resolve_hist;

  assign ras_push      = done && tb_hit && (tb_kind == BR_CALL);
  assign ras_pop       = done && tb_hit && (tb_kind == BR_RET);
  assign tb_install_en = resolve_valid && resolve_taken;
  assign flip_en       = resolve_valid && resolve_mispredict && (resolve_kind == BR_COND);

  always_ff @(posedge clk) begin
    if (rst) begin
      req_q  <= 1'b0;
      ip_q   <= RESET_IP;
      hist_q <= '0;
    end else if (req_q) begin
      if (fetch_ack) begin
        req_q  <= 1'b0;
        ip_q   <= next_ip;
        hist_q <= next_hist;
      end
    end else if (resolve_valid) begin
      if (resolve_mispredict) begin
        ip_q   <= redir_ip;
        hist_q <= redir_hist;
      end
    end else if (!fetch_ack) begin
      req_q <= 1'b1;    // consumer dropped ack, start next fetch
    end
  end

endmodule

/* verilog/frontend_top.sv */
// fetch front end top, control plus predictor, target buffer and return stack
// lookups use the current fetch block, writes come from resolve or completion
`timescale 1ns/1ns

module frontend_top import fe_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  output logic     fetch_req,
  output ip_t      fetch_ip,
  output hist_t    fetch_hist,
  input  logic     fetch_ack,
  input  logic     resolve_valid,
  input  ip_t      resolve_ip,
  input  ip_t      resolve_target,
  input  br_kind_t resolve_kind,
  input  logic     resolve_taken,
  input  hist_t    resolve_hist,
  input  logic     resolve_mispredict
);

  logic     tb_hit;
  br_kind_t tb_kind;
  ip_t      tb_target;
  logic     vote;
  ip_t      ras_top;
  logic     ras_push;
  logic     ras_pop;
  logic     tb_install_en;
  logic     flip_en;

  fetch_ctrl u_ctrl (
    .clk                (clk),
    .rst                (rst),
    .fetch_req          (fetch_req),
    .fetch_ack          (fetch_ack),
    .fetch_ip           (fetch_ip),
    .fetch_hist         (fetch_hist),
    .resolve_valid      (resolve_valid),
    .resolve_ip         (resolve_ip),
    .resolve_target     (resolve_target),
    .resolve_kind       (resolve_kind),
    .resolve_taken      (resolve_taken),
    .resolve_hist       (resolve_hist),
    .resolve_mispredict (resolve_mispredict),
    .tb_hit             (tb_hit),
    .tb_kind            (tb_kind),
    .tb_target          (tb_target),
    .vote               (vote),
    .ras_top            (ras_top),
    .ras_push           (ras_push),
    .ras_pop            (ras_pop),
    .tb_install_en      (tb_install_en),
    .flip_en            (flip_en)
  );

  dir_predictor u_pred (
    .clk         (clk),
    .rst         (rst),
    .lookup_ip   (fetch_ip),
    .lookup_hist (fetch_hist),
    .vote        (vote),
    .flip_en     (flip_en),
    .flip_ip     (resolve_ip),
    .flip_hist   (resolve_hist)
  );

  target_buffer u_btb (
    .clk            (clk),
    .rst            (rst),
    .lookup_ip      (fetch_ip),
    .hit            (tb_hit),
    .hit_kind       (tb_kind),
    .hit_target     (tb_target),
    .install_en     (tb_install_en),
    .install_ip     (resolve_ip),
    .install_target (resolve_target),
    .install_kind   (resolve_kind)
  );

  return_stack u_ras (
    .clk     (clk),
    .rst     (rst),
    .push    (ras_push),
    .push_ip (fetch_ip),   // return point formed inside the stack
    .pop     (ras_pop),
    .top_ip  (ras_top)
  );

endmodule

/* verification/fetch_checker.sv */
// handshake rules of the fetch port, bound into fetch_ctrl
// assumes resolve pulses only arrive between fetches
`timescale 1ns/1ns

module fetch_checker import fe_pkg::*; (
  input logic  clk,
  input logic  rst,
  input logic  fetch_req,
  input logic  fetch_ack,
  input ip_t   fetch_ip,
  input hist_t fetch_hist,
  input logic  resolve_valid
);

  int unsigned fail_count = 0;

  // req register is cleared one edge into reset
  a_reset_low: assert property (@(posedge clk) rst && $past(rst) |-> !fetch_req)
    else begin
      fail_count++;
      $error("fetch_req high during reset");
    end

  a_req_held: assert property (@(posedge clk) disable iff (rst)
    fetch_req && !fetch_ack |=> fetch_req)
    else begin
      fail_count++;
      $error("fetch_req dropped before fetch_ack");
    end

  a_ip_stable: assert property (@(posedge clk) disable iff (rst)
    fetch_req && $past(fetch_req) |-> $stable(fetch_ip) && $stable(fetch_hist))
    else begin
      fail_count++;
      $error("fetch_ip or fetch_hist moved while fetch_req high");
    end

  a_resolve_gap: assert property (@(posedge clk) disable iff (rst)
    resolve_valid |-> !fetch_req)
    else begin
      fail_count++;
      $error("resolve_valid seen with fetch_req high");
    end

endmodule

bind fetch_ctrl fetch_checker u_chk (
  .clk           (clk),
  .rst           (rst),
  .fetch_req     (fetch_req),
  .fetch_ack     (fetch_ack),
  .fetch_ip      (fetch_ip),
  .fetch_hist    (fetch_hist),
  .resolve_valid (resolve_valid)
);

/* verification/frontend_tb.sv */
// testbench for frontend_top, random ack delays and resolves from a fixed seed
// resolves are only driven in the gap between two fetches
`timescale 1ns/1ns

module frontend_tb import fe_pkg::*;;

  localparam int N_SEQ      = 20;
  localparam int N_COND     = 60;
  localparam int N_RET_WALK = 30;
  localparam int N_QUIET    = 10;
  // alias test 14, call setup 21, install-in-flight 3
  localparam int TOTAL_FETCHES = N_SEQ + 14 + N_COND + 21 + N_RET_WALK + N_QUIET + 3;
  localparam int TIMEOUT_NS    = (8 + 20 * TOTAL_FETCHES) * 10;

  logic     clk = 1'b0;
  logic     rst;
  logic     fetch_req;
  ip_t      fetch_ip;
  hist_t    fetch_hist;
  logic     fetch_ack;
  logic     resolve_valid;
  ip_t      resolve_ip;
  ip_t      resolve_target;
  br_kind_t resolve_kind;
  logic     resolve_taken;
  hist_t    resolve_hist;
  logic     resolve_mispredict;

  logic [31:0] rng = 32'd97;
  int unsigned n_chk = 0;
  int unsigned n_err = 0;
  int unsigned test_err = 0;

  // reference model state
  ip_t         m_ip;
  hist_t       m_hist;
  logic        va [256];
  logic        vb [256];
  logic        vc [256];
  int unsigned m_sel;
  logic        mt_valid [64];
  logic [31:0] mt_tag [64];
  ip_t         mt_target [64];
  br_kind_t    mt_kind [64];
  ip_t         mras [8];
  logic [2:0]  mras_ptr;

  frontend_top u_dut (
    .clk                (clk),
    .rst                (rst),
    .fetch_req          (fetch_req),
    .fetch_ip           (fetch_ip),
    .fetch_hist         (fetch_hist),
    .fetch_ack          (fetch_ack),
    .resolve_valid      (resolve_valid),
    .resolve_ip         (resolve_ip),
    .resolve_target     (resolve_target),
    .resolve_kind       (resolve_kind),
    .resolve_taken      (resolve_taken),
    .resolve_hist       (resolve_hist),
    .resolve_mispredict (resolve_mispredict)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    rng = xorshift32(rng);
    return rng % n;
  endfunction

  // aligned block somewhere in the n blocks above base
  function automatic ip_t rand_block(input ip_t base, input int unsigned n);
    return base + (ip_t'(rand_below(n)) << OFF_W);
  endfunction

  function automatic logic [7:0] a_index(input ip_t ip, input hist_t h);
    return {ip[10:5], h[1:0]};
  endfunction

  function automatic logic [7:0] b_index(input ip_t ip, input hist_t h);
    return {ip[8:5], h[3:0]};
  endfunction

  function automatic logic model_vote(input ip_t ip, input hist_t h);
    return va[a_index(ip, h)] ^ vb[b_index(ip, h)] ^ vc[h];
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_chk++;
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
      n_err++;
      test_err++;
    end
  endtask

  task automatic end_test(input string name);
    $display("%-24s %s, %0d errors", name, (test_err == 0) ? "ok" : "FAIL", test_err);
    test_err = 0;
  endtask

  // next block and history when the fetch at m_ip completes
  task automatic model_complete();
    logic [5:0] idx;
    ip_t        seq;
    logic       v;
    idx = m_ip[10:5];
    seq = m_ip + IP_W'(FETCH_BYTES);
    v   = model_vote(m_ip, m_hist);
    if (mt_valid[idx] && mt_tag[idx] == m_ip[42:11]) begin
      case (mt_kind[idx])
        BR_RET: begin
          m_ip     = mras[mras_ptr];
          mras_ptr = mras_ptr - 3'd1;
        end
        BR_CALL: begin
          mras_ptr       = mras_ptr + 3'd1;
          mras[mras_ptr] = seq;
          m_ip           = mt_target[idx];
        end
        BR_UNCOND: m_ip = mt_target[idx];
        default: begin
          m_ip   = v ? mt_target[idx] : seq;
          m_hist = {m_hist[6:0], v};
        end
      endcase
    end else begin
      m_ip = seq;
    end
  endtask

  task automatic model_resolve(input ip_t ip, input ip_t tgt, input br_kind_t kind,
                               input logic taken, input hist_t h, input logic misp);
    logic [5:0] idx;
    idx = ip[10:5];
    if (taken) begin
      mt_valid[idx]  = 1'b1;
      mt_tag[idx]    = ip[42:11];
      mt_target[idx] = {tgt[42:5], 5'b0};
      mt_kind[idx]   = kind;
    end
    if (misp && kind == BR_COND) begin
      case (m_sel)
        0:       va[a_index(ip, h)] = ~va[a_index(ip, h)];
        1:       vb[b_index(ip, h)] = ~vb[b_index(ip, h)];
        default: vc[h] = ~vc[h];
      endcase
      m_sel = (m_sel + 1) % 3;
    end
    if (misp) begin
      m_ip   = taken ? tgt : ip + IP_W'(FETCH_BYTES);
      m_hist = (kind == BR_COND) ? {h[6:0], taken} : h;
    end
  endtask

  // one full four-phase fetch, returns on the falling edge where ack drops
  task automatic run_fetch();
    int unsigned d;
    @(negedge clk);
    while (!fetch_req) @(negedge clk);
    check_val("fetch_ip", 64'(fetch_ip), 64'(m_ip));
    check_val("fetch_hist", 64'(fetch_hist), 64'(m_hist));
    d = rand_below(4);
    repeat (d) @(negedge clk);
    fetch_ack = 1'b1;
    @(negedge clk);
    while (fetch_req) @(negedge clk);
    model_complete();
    d = rand_below(3);   // consumer holds ack a while
    repeat (d) @(negedge clk);
    fetch_ack = 1'b0;
  endtask

  // only legal right after run_fetch returns
  task automatic send_resolve(input ip_t ip, input ip_t tgt, input br_kind_t kind,
                              input logic taken, input hist_t h, input logic misp);
    resolve_valid      = 1'b1;
    resolve_ip         = ip;
    resolve_target     = tgt;
    resolve_kind       = kind;
    resolve_taken      = taken;
    resolve_hist       = h;
    resolve_mispredict = misp;
    @(negedge clk);
    resolve_valid = 1'b0;
    model_resolve(ip, tgt, kind, taken, h, misp);
  endtask

  initial begin
    #TIMEOUT_NS;
    $display("timeout: fetch sequence stalled before all tests finished");
    $display("Test failed");
    $finish;
  end

  initial begin
    ip_t      prev_ip;
    hist_t    prev_h;
    ip_t      b1;
    ip_t      b2;
    ip_t      tgt;
    ip_t      base;
    ip_t      r_ip;
    br_kind_t kind;
    logic     taken;
    logic     misp;

    rst                = 1'b1;
    fetch_ack          = 1'b0;
    resolve_valid      = 1'b0;
    resolve_ip         = '0;
    resolve_target     = '0;
    resolve_kind       = BR_COND;
    resolve_taken      = 1'b0;
    resolve_hist       = '0;
    resolve_mispredict = 1'b0;

    m_ip     = RESET_IP;
    m_hist   = '0;
    m_sel    = 0;
    mras_ptr = '0;
    for (int i = 0; i < 256; i++) begin
      va[i] = 1'b0;
      vb[i] = 1'b0;
      vc[i] = 1'b0;
    end
    for (int i = 0; i < 64; i++) begin
      mt_valid[i]  = 1'b0;
      mt_tag[i]    = '0;
      mt_target[i] = '0;
      mt_kind[i]   = BR_COND;
    end
    for (int i = 0; i < 8; i++) begin
      mras[i] = '0;
    end

    repeat (8) @(negedge clk);
    rst = 1'b0;

    // empty target buffer, plain sequential blocks
    repeat (N_SEQ) run_fetch();
    end_test("sequential fetch");

    run_fetch();
    b1 = m_ip + IP_W'(FETCH_BYTES);
    send_resolve(b1, rand_block(43'h8000, 64), BR_UNCOND, 1'b1, m_hist, 1'b0);
    repeat (4) run_fetch();
    b2 = b1 + 43'd2048;   // same index, other tag
    run_fetch();
    send_resolve(b2, rand_block(43'hc000, 64), BR_UNCOND, 1'b1, m_hist, 1'b0);
    run_fetch();
    send_resolve(b2 - 43'd32, '0, BR_UNCOND, 1'b0, m_hist, 1'b1);
    repeat (3) run_fetch();
    run_fetch();
    send_resolve(b1 - 43'd32, '0, BR_UNCOND, 1'b0, m_hist, 1'b1);
    repeat (3) run_fetch();
    end_test("unconditional and alias");

    for (int i = 0; i < N_COND; i++) begin
      prev_ip = m_ip;
      prev_h  = m_hist;
      run_fetch();
      if (rand_below(2) == 0) begin
        tgt   = rand_block('0, 32);
        taken = 1'(rand_below(2));
        misp  = 1'(rand_below(2));
        send_resolve(prev_ip, tgt, BR_COND, taken, prev_h, misp);
      end
    end
    end_test("conditional and flips");

    // call chain ten deep, so the eight-entry stack wraps
    base = 43'h20000;
    for (int i = 0; i < 10; i++) begin
      run_fetch();
      if (i < 9) begin
        send_resolve(base + ip_t'(i * 64), base + ip_t'((i + 1) * 64), BR_CALL, 1'b1,
                     m_hist, 1'b0);
      end else begin
        send_resolve(base + ip_t'(i * 64), '0, BR_RET, 1'b1, m_hist, 1'b0);
      end
    end
    for (int i = 0; i < 10; i++) begin
      run_fetch();
      send_resolve(base + ip_t'(i * 64 + 32), '0, BR_RET, 1'b1, m_hist, 1'b0);
    end
    run_fetch();
    send_resolve(base - 43'd32, '0, BR_UNCOND, 1'b0, m_hist, 1'b1);
    repeat (N_RET_WALK) run_fetch();
    end_test("call and return stack");

    for (int i = 0; i < N_QUIET; i++) begin
      run_fetch();
      r_ip = rand_block(43'h40000, 64);
      tgt  = rand_block(43'h50000, 64);
      kind = br_kind_t'(2'(rand_below(4)));
      send_resolve(r_ip, tgt, kind, 1'b1, m_hist, 1'b0);
    end
    run_fetch();
    tgt = rand_block(43'h60000, 64);
    send_resolve(m_ip, tgt, BR_UNCOND, 1'b1, m_hist, 1'b0);
    run_fetch();   // same block, now leaves through the new entry
    run_fetch();
    end_test("install without redirect");

    if (u_dut.u_ctrl.u_chk.fail_count != 0) begin
      $display("handshake assertions failed %0d times", u_dut.u_ctrl.u_chk.fail_count);
      n_err += u_dut.u_ctrl.u_chk.fail_count;
    end
    $display("checks %0d, errors %0d", n_chk, n_err);
    if (n_err == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* tb.f */
verilog/fe_pkg.sv
verilog/table_ram.sv
verilog/dir_predictor.sv
verilog/target_buffer.sv
verilog/return_stack.sv
verilog/fetch_ctrl.sv
verilog/frontend_top.sv
verification/fetch_checker.sv
verification/frontend_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       ?= frontend_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "no verdict in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
